// File: hw/mem_map_pkg.sv
// Single fixed size with 1 MB SRAM at zero, DDR from 2 GB up, and anything between decodes as unmapped
package mem_map_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 64;
    localparam int INST_W      = 32;
    localparam int BE_W        = DATA_W / 8;
    localparam int BURST_BEATS = 4;
    localparam int BURST_LEN_W = 2;

    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] SRAM_SIZE = 32'h0010_0000;
    localparam logic [ADDR_W-1:0] DDR_BASE  = 32'h8000_0000;

    typedef enum logic [1:0] {
        REGION_SRAM,
        REGION_DDR,
        REGION_NONE
    } region_e;

    // Same address word seen by the decoder and by the DDR line buffer
    typedef union packed {
        // 1 MB granules for the region check
        struct packed {
            logic [11:0] region;
            logic [16:0] word;
            logic [2:0]  byte_off;
        } sram;
        // Four 64-bit words per DDR line
        struct packed {
            logic [26:0] tag;
            logic [1:0]  word;
            logic [2:0]  byte_off;
        } ddr;
    } addr_view_u;

endpackage

// File: hw/bus_pkg.sv
// Transaction bundles at the fixed widths of mem_map_pkg; the bus keeps only one request in flight
package bus_pkg;

    // Request latched by the bus and handed to exactly one target
    typedef struct packed {
        logic [mem_map_pkg::ADDR_W-1:0] addr;
        logic                           we;
        logic [mem_map_pkg::DATA_W-1:0] wdata;
        logic [mem_map_pkg::BE_W-1:0]   be;
        logic                           is_inst;
    } cpu_req_t;

    // DDR request, qualified by mem_req_valid
    typedef struct packed {
        logic [mem_map_pkg::ADDR_W-1:0]      addr;
        logic                                we;
        logic [mem_map_pkg::DATA_W-1:0]      wdata;
        logic [mem_map_pkg::BE_W-1:0]        be;
        // Beats minus one
        logic [mem_map_pkg::BURST_LEN_W-1:0] burst_len;
    } mem_req_t;

    // SRAM strobes, held until sram_ready
    typedef struct packed {
        logic [mem_map_pkg::ADDR_W-1:0] addr;
        logic [mem_map_pkg::DATA_W-1:0] wdata;
        logic [mem_map_pkg::BE_W-1:0]   be;
        logic                           we;
        logic                           re;
    } sram_req_t;

endpackage

// File: hw/sram_port.sv
// Strobes drive from the start cycle and hold until sram_ready; read data is sampled with ready
`timescale 1ns/1ps

module sram_port (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  bus_pkg::cpu_req_t              req,
    output logic                           done,
    output logic [mem_map_pkg::DATA_W-1:0] rdata,
    output bus_pkg::sram_req_t             sram_req,
    input  logic [mem_map_pkg::DATA_W-1:0] sram_rdata,
    input  logic                           sram_ready
);

    logic              active;
    logic              strobe;
    bus_pkg::cpu_req_t held;
    bus_pkg::cpu_req_t src;

    assign strobe = start || active;
    assign src    = start ? req : held;

    always_comb begin
        sram_req.addr  = src.addr;
        sram_req.wdata = src.wdata;
        sram_req.be    = src.be;
        sram_req.we    = strobe && src.we;
        sram_req.re    = strobe && !src.we;
    end

    // Waiting on a stalled SRAM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            active <= strobe && !sram_ready;
            done   <= strobe && sram_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            held <= req;
        end
        if (strobe && sram_ready) begin
            rdata <= sram_rdata;
        end
    end

    // Strobe and request stay put until the SRAM takes them
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        strobe && !sram_ready |=> strobe && $stable(sram_req));

endmodule

// File: hw/memory_burst_buffer.sv
// One buffered DDR line of four beats; reads fill by whole line, writes pass through as single beats
`timescale 1ns/1ps

module memory_burst_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  bus_pkg::cpu_req_t              req,
    output logic                           done,
    output logic [mem_map_pkg::DATA_W-1:0] rdata,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output bus_pkg::mem_req_t              mem_req,
    input  logic                           mem_resp_valid,
    output logic                           mem_resp_ready,
    input  logic [mem_map_pkg::DATA_W-1:0] mem_resp_rdata
);

    logic [mem_map_pkg::DATA_W-1:0]            line_data [mem_map_pkg::BURST_BEATS];
    logic [mem_map_pkg::ADDR_W-6:0]            line_tag;
    logic                                      line_valid;
    logic [$clog2(mem_map_pkg::BURST_BEATS)-1:0] beat_cnt;
    logic [$clog2(mem_map_pkg::BURST_BEATS)-1:0] word_q;
    logic                                      fill_active;
    logic                                      hit;
    logic                                      req_fire;
    logic                                      beat_fire;
    logic                                      last_beat;
    mem_map_pkg::addr_view_u                   req_view;
    mem_map_pkg::addr_view_u                   line_addr;

    assign req_view  = req.addr;
    assign hit       = line_valid && (line_tag == req_view.ddr.tag);
    assign req_fire  = mem_req_valid && mem_req_ready;
    assign beat_fire = mem_resp_valid && mem_resp_ready;
    // Last beat of the line
    assign last_beat = beat_fire && (beat_cnt == '1);

    assign mem_resp_ready = fill_active;

    // Bursts always start at word 0 of the line
    always_comb begin
        line_addr              = req_view;
        line_addr.ddr.word     = '0;
        line_addr.ddr.byte_off = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
            fill_active   <= 1'b0;
            beat_cnt      <= '0;
            line_valid    <= 1'b0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                if (req.we) begin
                    mem_req_valid <= 1'b1;
                end else if (hit) begin
                    done <= 1'b1;
                end else begin
                    // Old line is lost once the refill starts
                    mem_req_valid <= 1'b1;
                    line_valid    <= 1'b0;
                end
            end
            if (req_fire) begin
                mem_req_valid <= 1'b0;
                if (mem_req.we) begin
                    done <= 1'b1;
                end else begin
                    fill_active <= 1'b1;
                    beat_cnt    <= '0;
                end
            end
            if (beat_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    fill_active <= 1'b0;
                    line_valid  <= 1'b1;
                    done        <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            word_q <= req_view.ddr.word;
            if (req.we) begin
                mem_req.addr      <= req.addr;
                mem_req.we        <= 1'b1;
                mem_req.wdata     <= req.wdata;
                mem_req.be        <= req.be;
                mem_req.burst_len <= '0;
                // Keep the buffered copy coherent
                if (hit) begin
                    for (int b = 0; b < mem_map_pkg::BE_W; b++) begin
                        if (req.be[b]) begin
                            line_data[req_view.ddr.word][8*b +: 8] <= req.wdata[8*b +: 8];
                        end
                    end
                end
            end else if (hit) begin
                rdata <= line_data[req_view.ddr.word];
            end else begin
                line_tag          <= req_view.ddr.tag;
                mem_req.addr      <= line_addr;
                mem_req.we        <= 1'b0;
                mem_req.wdata     <= '0;
                mem_req.be        <= '1;
                // Full line, beats minus one
                mem_req.burst_len <= '1;
            end
        end
        if (beat_fire) begin
            line_data[beat_cnt] <= mem_resp_rdata;
            if (beat_cnt == word_q) begin
                rdata <= mem_resp_rdata;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

// File: hw/memory_bus.sv
// CPU requests are levels held until a one-cycle ready; data wins over instruction, one at a time
`timescale 1ns/1ps

module memory_bus (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mem_map_pkg::ADDR_W-1:0] imem_addr,
    input  logic                           imem_read,
    output logic [mem_map_pkg::INST_W-1:0] imem_rdata,
    output logic                           imem_ready,
    output logic                           imem_err,
    input  logic [mem_map_pkg::ADDR_W-1:0] dmem_addr,
    input  logic [mem_map_pkg::DATA_W-1:0] dmem_wdata,
    input  logic [mem_map_pkg::BE_W-1:0]   dmem_be,
    input  logic                           dmem_read,
    input  logic                           dmem_write,
    output logic [mem_map_pkg::DATA_W-1:0] dmem_rdata,
    output logic                           dmem_ready,
    output logic                           dmem_err,
    output bus_pkg::sram_req_t             sram_req,
    input  logic [mem_map_pkg::DATA_W-1:0] sram_rdata,
    input  logic                           sram_ready,
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output bus_pkg::mem_req_t              mem_req,
    input  logic                           mem_resp_valid,
    output logic                           mem_resp_ready,
    input  logic [mem_map_pkg::DATA_W-1:0] mem_resp_rdata
);

    logic                           dmem_pick;
    logic                           imem_pick;
    logic                           accept;
    logic                           busy;
    logic                           start_q;
    logic                           none_done;
    logic                           sram_start;
    logic                           ddr_start;
    logic                           sram_done;
    logic                           ddr_done;
    logic                           resp_done;
    logic [mem_map_pkg::DATA_W-1:0] sram_port_rdata;
    logic [mem_map_pkg::DATA_W-1:0] ddr_rdata;
    logic [mem_map_pkg::DATA_W-1:0] resp_data;
    bus_pkg::cpu_req_t              next_req;
    bus_pkg::cpu_req_t              req_q;
    mem_map_pkg::addr_view_u        req_view;
    mem_map_pkg::addr_view_u        sram_lo;
    mem_map_pkg::addr_view_u        sram_hi;
    mem_map_pkg::addr_view_u        ddr_lo;
    mem_map_pkg::region_e           region;

    // Data port always first
    always_comb begin
        dmem_pick = dmem_read || dmem_write;
        imem_pick = imem_read && !dmem_pick;
        next_req  = '0;
        if (dmem_pick) begin
            next_req.addr  = dmem_addr;
            next_req.we    = dmem_write;
            next_req.wdata = dmem_wdata;
            next_req.be    = dmem_be;
        end else begin
            next_req.addr    = imem_addr;
            next_req.be      = '1;
            next_req.is_inst = 1'b1;
        end
    end

    assign accept = !busy && (dmem_pick || imem_pick);

    // Map boundaries in 1 MB granules
    assign sram_lo  = mem_map_pkg::SRAM_BASE;
    assign sram_hi  = mem_map_pkg::SRAM_BASE + mem_map_pkg::SRAM_SIZE;
    assign ddr_lo   = mem_map_pkg::DDR_BASE;
    assign req_view = req_q.addr;

    always_comb begin
        if (req_view.sram.region >= sram_lo.sram.region &&
            req_view.sram.region < sram_hi.sram.region) begin
            region = mem_map_pkg::REGION_SRAM;
        end else if (req_view.sram.region >= ddr_lo.sram.region) begin
            region = mem_map_pkg::REGION_DDR;
        end else begin
            region = mem_map_pkg::REGION_NONE;
        end
    end

    assign sram_start = start_q && (region == mem_map_pkg::REGION_SRAM);
    assign ddr_start  = start_q && (region == mem_map_pkg::REGION_DDR);

    // Busy from latch until the ready pulse has gone out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            start_q   <= 1'b0;
            none_done <= 1'b0;
        end else begin
            start_q   <= accept;
            none_done <= start_q && (region == mem_map_pkg::REGION_NONE);
            if (accept) begin
                busy <= 1'b1;
            end else if (imem_ready || dmem_ready) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= next_req;
        end
    end

    // Unmapped accesses answer with zero data
    assign resp_done = sram_done || ddr_done || none_done;
    assign resp_data = sram_done ? sram_port_rdata : (ddr_done ? ddr_rdata : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_ready <= 1'b0;
            dmem_ready <= 1'b0;
            imem_err   <= 1'b0;
            dmem_err   <= 1'b0;
        end else begin
            imem_ready <= resp_done && req_q.is_inst;
            dmem_ready <= resp_done && !req_q.is_inst;
            imem_err   <= none_done && req_q.is_inst;
            dmem_err   <= none_done && !req_q.is_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_done && req_q.is_inst) begin
            // Address bit 2 picks the upper instruction
            imem_rdata <= req_view.sram.byte_off[2] ? resp_data[63:32] : resp_data[31:0];
        end
        if (resp_done && !req_q.is_inst) begin
            dmem_rdata <= resp_data;
        end
    end

    sram_port u_sram_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (sram_start),
        .req        (req_q),
        .done       (sram_done),
        .rdata      (sram_port_rdata),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .sram_ready (sram_ready)
    );

    memory_burst_buffer u_burst_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (ddr_start),
        .req            (req_q),
        .done           (ddr_done),
        .rdata          (ddr_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_rdata (mem_resp_rdata)
    );

    // At most one target answers per request
    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sram_done, ddr_done, none_done}));

endmodule

// File: bench/tb_clock_gen.sv
// Free-running 40 ns clock; rst_n low for the first two rising edges, released 1 ns after the second
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: bench/tb_mem_models.sv
// Sparse behavioral memories; an unwritten 64-bit word reads as its own byte address in both halves
`timescale 1ns/1ps

module sram_model (
    input  logic               clk,
    input  logic               stall,
    input  bus_pkg::sram_req_t sram_req,
    output logic [63:0]        sram_rdata,
    output logic               sram_ready
);

    logic [63:0] mem [logic [31:0]];
    logic [31:0] key;

    assign sram_ready = !stall;
    assign key        = {sram_req.addr[31:3], 3'b000};

    always_comb begin
        if (mem.exists(key)) begin
            sram_rdata = mem[key];
        end else begin
            sram_rdata = {key, key};
        end
    end

    always @(posedge clk) begin
        logic [63:0] w;
        if (sram_req.we && sram_ready) begin
            w = mem.exists(key) ? mem[key] : {key, key};
            for (int b = 0; b < 8; b++) begin
                if (sram_req.be[b]) begin
                    w[8*b +: 8] = sram_req.wdata[8*b +: 8];
                end
            end
            mem[key] = w;
        end
    end

endmodule

module ddr_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              mem_req_valid,
    output logic              mem_req_ready,
    input  bus_pkg::mem_req_t mem_req,
    output logic              mem_resp_valid,
    input  logic              mem_resp_ready,
    output logic [63:0]       mem_resp_rdata
);

    logic [63:0] mem [logic [31:0]];
    logic        burst_on;
    logic [31:0] line_base;
    logic [1:0]  beat;
    logic [1:0]  last_beat;
    logic [31:0] beat_key;

    assign mem_req_ready  = !stall;
    // Stall also opens gaps between response beats
    assign mem_resp_valid = burst_on && !stall;
    assign beat_key       = {line_base[31:5], beat, 3'b000};

    always_comb begin
        if (mem.exists(beat_key)) begin
            mem_resp_rdata = mem[beat_key];
        end else begin
            mem_resp_rdata = {beat_key, beat_key};
        end
    end

    always @(posedge clk or negedge rst_n) begin
        logic [31:0] k;
        logic [63:0] w;
        if (!rst_n) begin
            burst_on  <= 1'b0;
            beat      <= 2'd0;
            last_beat <= 2'd0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.we) begin
                    k = {mem_req.addr[31:3], 3'b000};
                    w = mem.exists(k) ? mem[k] : {k, k};
                    for (int b = 0; b < 8; b++) begin
                        if (mem_req.be[b]) begin
                            w[8*b +: 8] = mem_req.wdata[8*b +: 8];
                        end
                    end
                    mem[k] = w;
                end else begin
                    burst_on  <= 1'b1;
                    line_base <= mem_req.addr;
                    beat      <= 2'd0;
                    last_beat <= mem_req.burst_len;
                end
            end
            if (mem_resp_valid && mem_resp_ready) begin
                beat <= beat + 2'd1;
                if (beat == last_beat) begin
                    burst_on <= 1'b0;
                end
            end
        end
    end

endmodule

// File: bench/tb_memory_bus.sv
// One CPU access or one data plus instruction pair at a time; expected words come from a write shadow
`timescale 1ns/1ps

module tb_memory_bus;

    localparam int WAIT_LIMIT = 400;

    logic               clk;
    logic               rst_n;
    logic [31:0]        imem_addr;
    logic               imem_read;
    logic [31:0]        imem_rdata;
    logic               imem_ready;
    logic               imem_err;
    logic [31:0]        dmem_addr;
    logic [63:0]        dmem_wdata;
    logic [7:0]         dmem_be;
    logic               dmem_read;
    logic               dmem_write;
    logic [63:0]        dmem_rdata;
    logic               dmem_ready;
    logic               dmem_err;
    bus_pkg::sram_req_t sram_req;
    logic [63:0]        sram_rdata;
    logic               sram_ready;
    logic               mem_req_valid;
    logic               mem_req_ready;
    bus_pkg::mem_req_t  mem_req;
    logic               mem_resp_valid;
    logic               mem_resp_ready;
    logic [63:0]        mem_resp_rdata;
    logic               sram_stall;
    logic               ddr_stall;
    logic               stall_en;
    logic [31:0]        rng;
    logic [63:0]        exp_d;
    logic [31:0]        exp_i;
    logic               exp_derr;
    logic               exp_ierr;
    logic               chk_d;
    logic               d_we;
    logic               no_target;
    logic [63:0]        shadow [logic [31:0]];
    int                 hs_count;
    int                 errors;
    int                 accesses;
    int                 tests_failed;

    tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    sram_model sram_mem (
        .clk(clk), .stall(sram_stall), .sram_req(sram_req),
        .sram_rdata(sram_rdata), .sram_ready(sram_ready)
    );

    ddr_model ddr_mem (
        .clk(clk), .rst_n(rst_n), .stall(ddr_stall),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid), .mem_resp_ready(mem_resp_ready),
        .mem_resp_rdata(mem_resp_rdata)
    );

    memory_bus memory_bus_i (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_read(imem_read), .imem_rdata(imem_rdata),
        .imem_ready(imem_ready), .imem_err(imem_err),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
        .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready), .dmem_err(dmem_err),
        .sram_req(sram_req), .sram_rdata(sram_rdata), .sram_ready(sram_ready),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid), .mem_resp_ready(mem_resp_ready),
        .mem_resp_rdata(mem_resp_rdata)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] expect_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:3], 3'b000};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return {key, key};
    endfunction

    function automatic logic unmapped(input logic [31:0] addr);
        return addr >= mem_map_pkg::SRAM_SIZE && addr < mem_map_pkg::DDR_BASE;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_text(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic abort_run(input string why);
        $display("Aborted: %s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic shadow_write(input logic [31:0] addr, input logic [63:0] wdata,
                                input logic [7:0] be);
        logic [63:0] w;
        w = expect_word(addr);
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        shadow[{addr[31:3], 3'b000}] = w;
    endtask

    task automatic set_data(input logic [31:0] addr, input logic we, input logic [63:0] wdata,
                            input logic [7:0] be);
        dmem_addr  = addr;
        dmem_wdata = wdata;
        dmem_be    = be;
        d_we       = we;
        exp_derr   = unmapped(addr);
        exp_d      = exp_derr ? 64'h0 : expect_word(addr);
        // Write responses carry no defined data except on the error path
        chk_d      = !we || exp_derr;
        if (we && !exp_derr) begin
            shadow_write(addr, wdata, be);
        end
    endtask

    task automatic set_inst(input logic [31:0] addr);
        logic [63:0] w;
        w         = expect_word(addr);
        imem_addr = addr;
        exp_ierr  = unmapped(addr);
        exp_i     = exp_ierr ? 32'h0 : (addr[2] ? w[63:32] : w[31:0]);
    endtask

    task automatic drive_stalls();
        if (stall_en) begin
            rng        = lcg(rng);
            sram_stall = rng[16];
            ddr_stall  = rng[17] && rng[18];
        end else begin
            sram_stall = 1'b0;
            ddr_stall  = 1'b0;
        end
    endtask

    // Raise the request levels and hold each one until its ready pulse
    task automatic issue(input bit do_d, input bit do_i);
        int n;
        bit d_left;
        bit i_left;
        d_left     = do_d;
        i_left     = do_i;
        no_target  = (do_d && exp_derr) || (do_i && exp_ierr);
        dmem_read  = do_d && !d_we;
        dmem_write = do_d && d_we;
        imem_read  = do_i;
        n = 0;
        while ((d_left || i_left) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
            drive_stalls();
            if (i_left && imem_ready) begin
                assert (!d_left) else report_text("instruction ready came before data ready");
                i_left    = 0;
                imem_read = 1'b0;
                accesses++;
            end
            if (d_left && dmem_ready) begin
                d_left     = 0;
                dmem_read  = 1'b0;
                dmem_write = 1'b0;
                accesses++;
            end
        end
        if (d_left || i_left) begin
            abort_run("no ready pulse within the wait limit");
        end
        // Let the assertions sample this response before the next expected value
        @(posedge clk);
        #1;
        no_target = 1'b0;
    endtask

    task automatic check_handshakes(input int expected);
        assert (hs_count == expected)
            else report_value("mem_req handshakes", 64'(hs_count), 64'(expected));
    endtask

    task automatic end_test(input int idx, input string name, input int err_before);
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", idx, name, errors == err_before ? "ok" : "errors seen");
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_count <= 0;
        end else if (mem_req_valid && mem_req_ready) begin
            hs_count <= hs_count + 1;
        end
    end

    a_dmem_data: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_ready && chk_d |-> dmem_rdata == exp_d)
        else report_value("dmem_rdata", dmem_rdata, exp_d);
    a_dmem_err: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_ready |-> dmem_err == exp_derr)
        else report_value("dmem_err", 64'(dmem_err), 64'(exp_derr));
    a_imem_data: assert property (@(posedge clk) disable iff (!rst_n)
        imem_ready |-> imem_rdata == exp_i)
        else report_value("imem_rdata", 64'(imem_rdata), 64'(exp_i));
    a_imem_err: assert property (@(posedge clk) disable iff (!rst_n)
        imem_ready |-> imem_err == exp_ierr)
        else report_value("imem_err", 64'(imem_err), 64'(exp_ierr));
    a_no_target: assert property (@(posedge clk) disable iff (!rst_n)
        no_target |-> !(sram_req.we || sram_req.re || mem_req_valid))
        else report_text("a target was strobed during an unmapped access");
    // Line fills are four beats, writes are single beats
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_ready |-> mem_req.burst_len == (mem_req.we ? 2'd0 : 2'd3))
        else report_value("mem_req.burst_len", 64'(mem_req.burst_len), mem_req.we ? 0 : 3);
    // The bus takes every beat while a fill is running
    a_resp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> mem_resp_ready)
        else report_text("mem_resp_ready was low while a fill beat was offered");

    initial begin : main_seq
        int n;
        int err0;
        int base;
        logic [31:0] r;
        logic [31:0] addr;
        imem_addr    = '0;
        imem_read    = 1'b0;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        dmem_be      = '0;
        dmem_read    = 1'b0;
        dmem_write   = 1'b0;
        sram_stall   = 1'b0;
        ddr_stall    = 1'b0;
        stall_en     = 1'b0;
        rng          = 32'he046574f;
        exp_d        = '0;
        exp_i        = '0;
        exp_derr     = 1'b0;
        exp_ierr     = 1'b0;
        chk_d        = 1'b0;
        d_we         = 1'b0;
        no_target    = 1'b0;
        errors       = 0;
        accesses     = 0;
        tests_failed = 0;
        n = 0;
        while (!rst_n && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            abort_run("reset was never released");
        end
        @(posedge clk);
        #1;

        err0 = errors;
        set_data(32'h0000_0000, 1'b0, '0, '0);
        issue(1, 0);
        set_data(32'h0000_1238, 1'b0, '0, '0);
        issue(1, 0);
        set_data(32'h0000_1238, 1'b1, 64'hdead_beef_cafe_f00d, 8'b0011_1100);
        issue(1, 0);
        set_data(32'h0000_1238, 1'b0, '0, '0);
        issue(1, 0);
        end_test(1, "sram read/write", err0);

        err0 = errors;
        base = hs_count;
        set_data(32'h8000_0050, 1'b0, '0, '0);
        issue(1, 0);
        check_handshakes(base + 1);
        set_data(32'h8000_0040, 1'b0, '0, '0);
        issue(1, 0);
        set_data(32'h8000_0048, 1'b0, '0, '0);
        issue(1, 0);
        set_data(32'h8000_0058, 1'b0, '0, '0);
        issue(1, 0);
        check_handshakes(base + 1);
        end_test(2, "ddr line fill", err0);

        err0 = errors;
        base = hs_count;
        set_data(32'h8000_0048, 1'b1, 64'h0123_4567_89ab_cdef, 8'hf0);
        issue(1, 0);
        check_handshakes(base + 1);
        set_data(32'h8000_0048, 1'b0, '0, '0);
        issue(1, 0);
        check_handshakes(base + 1);
        end_test(3, "ddr write coherence", err0);

        err0 = errors;
        set_data(32'h0000_0200, 1'b1, 64'h1111_2222_3333_4444, 8'hff);
        issue(1, 0);
        set_inst(32'h0000_0200);
        issue(0, 1);
        set_inst(32'h0000_0204);
        issue(0, 1);
        set_data(32'h8000_0050, 1'b1, 64'h5555_6666_7777_8888, 8'hff);
        issue(1, 0);
        set_inst(32'h8000_0050);
        issue(0, 1);
        set_inst(32'h8000_0054);
        issue(0, 1);
        // Same-cycle requests, data must be answered first
        set_data(32'h0000_1238, 1'b0, '0, '0);
        set_inst(32'h8000_0044);
        issue(1, 1);
        end_test(4, "instruction fetch", err0);

        err0 = errors;
        set_data(32'h0010_0000, 1'b0, '0, '0);
        issue(1, 0);
        set_data(32'h4000_0000, 1'b1, 64'hffff_ffff_ffff_ffff, 8'hff);
        issue(1, 0);
        set_inst(32'h7fff_fffc);
        issue(0, 1);
        set_data(32'h000f_fff8, 1'b0, '0, '0);
        issue(1, 0);
        end_test(5, "unmapped address", err0);

        err0 = errors;
        stall_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            rng = lcg(rng);
            r   = rng;
            if (r[29:27] == 3'd0) begin
                addr = 32'h4000_0000 | {23'h0, r[15:10], 3'b000};
            end else if (r[27]) begin
                addr = {23'h0, r[15:10], 3'b000};
            end else begin
                addr = mem_map_pkg::DDR_BASE | {23'h0, r[15:10], 3'b000};
            end
            rng = lcg(rng);
            if (r[31:30] == 2'd2) begin
                set_inst(addr | {29'h0, r[9], 2'b00});
                issue(0, 1);
            end else begin
                set_data(addr, r[31:30] == 2'd1, {rng, ~rng}, r[23:16]);
                issue(1, 0);
            end
        end
        stall_en = 1'b0;
        drive_stalls();
        end_test(6, "random stalls", err0);

        $display("Tests 6, failed tests %0d, accesses %0d, errors %0d",
                 tests_failed, accesses, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
hw/mem_map_pkg.sv
hw/bus_pkg.sv
hw/sram_port.sv
hw/memory_burst_buffer.sv
hw/memory_bus.sv
bench/tb_clock_gen.sv
bench/tb_mem_models.sv
bench/tb_memory_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and pass only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_memory_bus -Mdir obj_dir -f project.f

out=$(./obj_dir/Vtb_memory_bus 2>&1) || true
echo "$out"
if grep -qx "Simulation finished: PASS" <<< "$out"; then
    exit 0
fi
exit 1
